// File: Makefile
# Verilator build and run of the HCI PIO testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_hci
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/tb_hci.sv
// Testbench for the HCI PIO path
// Random APB and controller traffic checked against queue models
`timescale 1ns/1ps

module tb_hci;

  localparam int TIMEOUT = 200;
  localparam int DEPTH   = 16;

  logic        clk;
  logic        rst_n;
  logic        psel, penable, pwrite, pready, pslverr;
  logic [11:0] paddr;
  logic [31:0] pwdata, prdata;
  logic        cmd_rvalid, cmd_rready, cmd_trig;
  logic [63:0] cmd_rdata;
  logic        resp_wvalid, resp_wready, resp_trig;
  logic [31:0] resp_wdata;

  logic [63:0] exp_cmd[$];
  logic [31:0] exp_resp[$];
  int          cmd_thld, resp_thld;
  int          seed = 20582;
  int          rdy_seed = 20582;
  int          rready_mode;  // 0 low, 1 random, 2 high
  int          errors;
  int          checks;
  string       test_name;

  hci_top DUT (
    .clk_i (clk), .rst_ni (rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .hci_cmd_rvalid_o (cmd_rvalid), .hci_cmd_rready_i (cmd_rready),
    .hci_cmd_rdata_o (cmd_rdata),
    .hci_resp_wvalid_i (resp_wvalid), .hci_resp_wready_o (resp_wready),
    .hci_resp_wdata_i (resp_wdata),
    .hci_cmd_ready_thld_trig_o (cmd_trig), .hci_resp_ready_thld_trig_o (resp_trig)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    #2;
    case (rready_mode)
      0:       cmd_rready = 1'b0;
      1:       cmd_rready = 1'($random(rdy_seed));
      default: cmd_rready = 1'b1;
    endcase
  end

  task automatic compare(input string what, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      $display("error %s: %s expected %h, actual %h", test_name, what, exp_val, act_val);
      errors++;
    end
  endtask

  // Transfers happen at the next edge, so sample between edges
  always @(negedge clk) begin
    if (rst_n && cmd_rvalid && cmd_rready) begin
      if (exp_cmd.size() == 0) begin
        $display("Unexpected command %h on the command port", cmd_rdata);
        errors++;
      end else begin
        compare("command", exp_cmd.pop_front(), cmd_rdata);
      end
    end
  end

  function automatic int thld_expect(int raw);
    if (raw < 1) return 1;
    if (raw > DEPTH) return DEPTH;
    return raw;
  endfunction

  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    psel   = 1'b1;
    pwrite = wr;
    paddr  = addr;
    pwdata = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    waits   = 0;
    @(negedge clk);
    while (!pready && waits < TIMEOUT) begin
      @(negedge clk);
      waits++;
    end
    if (!pready) begin
      $display("APB transfer to address %h never completed", addr);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    compare("write error", 64'd0, 64'(err));
  endtask

  task automatic write_pair(input logic [31:0] lo, input logic [31:0] hi);
    apb_write(hci_pkg::COMMAND_PORT_ADDR, lo);
    apb_write(hci_pkg::COMMAND_PORT_ADDR, hi);
    exp_cmd.push_back({hi, lo});
  endtask

  task automatic push_resp(input logic [31:0] data);
    resp_wdata  = data;
    resp_wvalid = 1'b1;
    @(negedge clk);
    compare("response wready", 64'd1, 64'(resp_wready));
    @(posedge clk);
    #2;
    resp_wvalid = 1'b0;
    exp_resp.push_back(data);
  endtask

  task automatic read_resp();
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, hci_pkg::RESPONSE_PORT_ADDR, '0, rd, err);
    if (exp_resp.size() == 0) begin
      compare("empty read error", 64'd1, 64'(err));
      compare("empty read data", 64'd0, 64'(rd));
    end else begin
      compare("response error", 64'd0, 64'(err));
      compare("response", 64'(exp_resp.pop_front()), 64'(rd));
    end
  endtask

  task automatic expect_status(input int cmd_cnt);
    logic [31:0] rd, exp_word;
    logic        err;
    exp_word = '0;
    exp_word[hci_pkg::CMD_CNT_LSB +: 5]  = 5'(cmd_cnt);
    exp_word[hci_pkg::RESP_CNT_LSB +: 5] = 5'(exp_resp.size());
    exp_word[hci_pkg::CMD_FULL_BIT]      = (cmd_cnt == DEPTH);
    exp_word[hci_pkg::RESP_EMPTY_BIT]    = (exp_resp.size() == 0);
    apb_xfer(1'b0, hci_pkg::QUEUE_STATUS_ADDR, '0, rd, err);
    compare("queue status", 64'(exp_word), 64'(rd));
  endtask

  task automatic wait_cmd_drain();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (exp_cmd.size() != 0 && cycles < 1000);
    if (exp_cmd.size() != 0) begin
      $display("Commands did not drain from the command port");
      errors++;
    end
    #2;
  endtask

  task automatic soft_reset(input int bit_pos);
    logic [31:0] rd;
    logic        err;
    int          polls;
    apb_write(hci_pkg::RESET_CONTROL_ADDR, 32'd1 << bit_pos);
    apb_xfer(1'b0, hci_pkg::RESET_CONTROL_ADDR, '0, rd, err);
    compare("reset bit readback", 64'd1 << bit_pos, 64'(rd));
    polls = 0;
    while (rd != '0 && polls < 20) begin
      apb_xfer(1'b0, hci_pkg::RESET_CONTROL_ADDR, '0, rd, err);
      polls++;
    end
    if (rd != '0) begin
      $display("Soft reset bit %0d did not clear", bit_pos);
      errors++;
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          n, raw_c, raw_r;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    cmd_rready = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata = '0;
    rready_mode = 0;
    test_name = "reset";
    repeat (3) @(posedge clk);
    compare("cmd rvalid", 64'd0, 64'(cmd_rvalid));
    compare("pslverr", 64'd0, 64'(pslverr));
    compare("cmd trigger", 64'd0, 64'(cmd_trig));
    compare("resp trigger", 64'd0, 64'(resp_trig));
    compare("resp wready", 64'd1, 64'(resp_wready));
    #2 rst_n = 1'b1;
    cmd_thld  = 1;
    resp_thld = 1;
    apb_xfer(1'b0, hci_pkg::QUEUE_THLD_CTRL_ADDR, '0, rd, err);
    compare("threshold reset value", 64'h0101, 64'(rd));
    expect_status(0);
    apb_xfer(1'b0, 12'h03C, '0, rd, err);  // Unmapped
    compare("unmapped error", 64'd1, 64'(err));
    compare("unmapped data", 64'd0, 64'(rd));

    test_name = "command order";
    rready_mode = 1;
    repeat (20) write_pair($random(seed), $random(seed));
    wait_cmd_drain();
    rready_mode = 0;

    test_name = "response order";
    repeat (4) begin
      n = 1 + {$random(seed)} % 8;
      repeat (n) begin
        repeat ({$random(seed)} % 4) begin
          @(posedge clk);
          #2;
        end
        push_resp($random(seed));
      end
      repeat (n) read_resp();
      read_resp();  // Underflow
    end

    test_name = "command back-pressure";
    repeat (DEPTH) write_pair($random(seed), $random(seed));
    expect_status(DEPTH);
    fork
      write_pair($random(seed), $random(seed));
      begin
        repeat (6) @(negedge clk);
        compare("stalled pready", 64'd0, 64'(pready));
        rready_mode = 2;
      end
    join
    wait_cmd_drain();
    rready_mode = 0;

    test_name = "thresholds";
    for (int i = 0; i < 6; i++) begin
      raw_c = (i == 0) ? 0 : {$random(seed)} % 256;
      raw_r = (i == 0) ? 255 : {$random(seed)} % 256;
      apb_write(hci_pkg::QUEUE_THLD_CTRL_ADDR, (raw_r << 8) | raw_c);
      cmd_thld  = thld_expect(raw_c);
      resp_thld = thld_expect(raw_r);
      apb_xfer(1'b0, hci_pkg::QUEUE_THLD_CTRL_ADDR, '0, rd, err);
      compare("threshold readback", 64'((resp_thld << 8) | cmd_thld), 64'(rd));
    end
    cmd_thld  = 1 + {$random(seed)} % DEPTH;
    resp_thld = 1 + {$random(seed)} % DEPTH;
    apb_write(hci_pkg::QUEUE_THLD_CTRL_ADDR, (resp_thld << 8) | cmd_thld);
    repeat (2) @(negedge clk);
    compare("idle cmd trigger", 64'd1, 64'(cmd_trig));
    compare("idle resp trigger", 64'd0, 64'(resp_trig));
    @(posedge clk);
    #2;
    for (int k = 0; k < DEPTH; k++) begin
      push_resp($random(seed));
      @(negedge clk);
      compare("resp trigger before", 64'(k >= resp_thld), 64'(resp_trig));
      @(negedge clk);
      compare("resp trigger after", 64'(k + 1 >= resp_thld), 64'(resp_trig));
      @(posedge clk);
      #2;
    end
    for (int k = 0; k < DEPTH; k++) begin
      write_pair($random(seed), $random(seed));
      @(negedge clk);  // Packer register loaded
      compare("cmd rvalid before", 64'(k > 0), 64'(cmd_rvalid));
      compare("cmd trigger before", 64'(DEPTH - k >= cmd_thld), 64'(cmd_trig));
      @(negedge clk);  // Queue written
      compare("cmd rvalid after", 64'd1, 64'(cmd_rvalid));
      @(negedge clk);
      compare("cmd trigger after", 64'(DEPTH - k - 1 >= cmd_thld), 64'(cmd_trig));
      @(posedge clk);
      #2;
    end

    test_name = "soft reset";
    apb_write(hci_pkg::COMMAND_PORT_ADDR, $random(seed));  // Half command
    soft_reset(hci_pkg::RESP_QUEUE_RST_BIT);
    exp_resp.delete();
    expect_status(DEPTH);
    read_resp();
    soft_reset(hci_pkg::CMD_QUEUE_RST_BIT);
    exp_cmd.delete();
    expect_status(0);
    rready_mode = 1;
    write_pair($random(seed), $random(seed));
    wait_cmd_drain();
    rready_mode = 0;
    expect_status(0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: source/cmd_dword_packer.sv
// Joins two COMMAND_PORT DWORDs into one 64-bit command
`timescale 1ns/1ps

module cmd_dword_packer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        dword_valid_i,
  input  logic [hci_pkg::DWORD_W-1:0] dword_i,
  input  logic                        flush_i,
  input  logic                        cmd_wready_i,
  output logic                        dword_ready_o,
  output logic                        cmd_wvalid_o,
  output logic [hci_pkg::CMD_W-1:0]   cmd_wdata_o
);

  logic                        half_q;  // Low DWORD held
  logic                        cmd_valid_q;
  logic [hci_pkg::DWORD_W-1:0] low_q;
  logic [hci_pkg::CMD_W-1:0]   cmd_q;
  logic                        take;

  // Second DWORD waits while the queue is full
  assign dword_ready_o = !cmd_valid_q && !(half_q && !cmd_wready_i);
  assign take          = dword_valid_i && dword_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q      <= 1'b0;
      cmd_valid_q <= 1'b0;
    end else if (flush_i) begin
      half_q      <= 1'b0;  // Drop partial and pending command
      cmd_valid_q <= 1'b0;
    end else begin
      if (cmd_valid_q && cmd_wready_i) cmd_valid_q <= 1'b0;
      if (take) begin
        half_q <= !half_q;
        if (half_q) cmd_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && !half_q) low_q <= dword_i;
    if (take && half_q) cmd_q <= {dword_i, low_q};  // First DWORD in low half
  end

  assign cmd_wvalid_o = cmd_valid_q;
  assign cmd_wdata_o  = cmd_q;

  // Register stage must never be overrun
  a_no_dword_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) dword_valid_i |-> dword_ready_o
  );

endmodule

// File: source/hci_csr.sv
// HCI register block on APB
// Command and response ports, queue thresholds, soft resets and status
`timescale 1ns/1ps

module hci_csr (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [hci_pkg::APB_AW-1:0]        paddr_i,
  input  logic [hci_pkg::DWORD_W-1:0]       pwdata_i,
  output logic [hci_pkg::DWORD_W-1:0]       prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,

  input  logic                              cmd_dword_ready_i,
  input  logic [hci_pkg::CNT_W-1:0]         cmd_count_i,
  input  logic                              cmd_flush_done_i,
  input  logic [hci_pkg::CNT_W-1:0]         resp_count_i,
  input  logic [hci_pkg::DWORD_W-1:0]       resp_rdata_i,
  input  logic                              resp_flush_done_i,

  output logic                              cmd_dword_valid_o,
  output logic [hci_pkg::DWORD_W-1:0]       cmd_dword_o,
  output logic [hci_pkg::THLD_W-1:0]        cmd_thld_o,
  output logic                              cmd_flush_o,
  output logic [hci_pkg::THLD_W-1:0]        resp_thld_o,
  output logic                              resp_flush_o,
  output logic                              resp_pop_o
);

  logic                        access;
  logic                        cmd_wr;
  logic                        wr_done;
  logic                        cmd_full;
  logic                        resp_empty;
  logic                        rd_err;
  logic [hci_pkg::DWORD_W-1:0] rdata;

  logic [hci_pkg::THLD_W-1:0]  cmd_thld_q;
  logic [hci_pkg::THLD_W-1:0]  resp_thld_q;
  logic                        cmd_rst_q;
  logic                        resp_rst_q;
  logic                        cmd_flush_q;
  logic                        resp_flush_q;

  // Keep a threshold inside 1..QUEUE_DEPTH
  function automatic logic [hci_pkg::THLD_W-1:0] clamp_thld(
    input logic [hci_pkg::THLD_W-1:0] value
  );
    logic [hci_pkg::THLD_W-1:0] result;
    if (value == '0) begin
      result = hci_pkg::THLD_MIN;
    end else if (value > hci_pkg::DEPTH_THLD) begin
      result = hci_pkg::DEPTH_THLD;
    end else begin
      result = value;
    end
    return result;
  endfunction

  assign access  = psel_i && penable_i;
  assign cmd_wr  = access && pwrite_i && (paddr_i == hci_pkg::COMMAND_PORT_ADDR);
  assign pready_o = !(cmd_wr && !cmd_dword_ready_i);  // Only stall source
  assign wr_done = access && pwrite_i && pready_o;

  assign cmd_dword_valid_o = cmd_wr && cmd_dword_ready_i;
  assign cmd_dword_o       = pwdata_i;

  assign cmd_full   = (cmd_count_i == hci_pkg::DEPTH_CNT);
  assign resp_empty = (resp_count_i == '0);
  assign resp_pop_o = access && !pwrite_i && !resp_empty &&
                      (paddr_i == hci_pkg::RESPONSE_PORT_ADDR);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= hci_pkg::THLD_MIN;
      resp_thld_q <= hci_pkg::THLD_MIN;
    end else if (wr_done && (paddr_i == hci_pkg::QUEUE_THLD_CTRL_ADDR)) begin
      cmd_thld_q  <= clamp_thld(pwdata_i[hci_pkg::CMD_THLD_LSB +: hci_pkg::THLD_W]);
      resp_thld_q <= clamp_thld(pwdata_i[hci_pkg::RESP_THLD_LSB +: hci_pkg::THLD_W]);
    end
  end

  // Reset bits stay set until the queue reports the flush done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q    <= 1'b0;
      resp_rst_q   <= 1'b0;
      cmd_flush_q  <= 1'b0;
      resp_flush_q <= 1'b0;
    end else begin
      cmd_flush_q  <= 1'b0;
      resp_flush_q <= 1'b0;
      if (cmd_flush_done_i) cmd_rst_q <= 1'b0;
      if (resp_flush_done_i) resp_rst_q <= 1'b0;
      if (wr_done && (paddr_i == hci_pkg::RESET_CONTROL_ADDR)) begin
        if (pwdata_i[hci_pkg::CMD_QUEUE_RST_BIT]) begin
          cmd_rst_q   <= 1'b1;
          cmd_flush_q <= 1'b1;
        end
        if (pwdata_i[hci_pkg::RESP_QUEUE_RST_BIT]) begin
          resp_rst_q   <= 1'b1;
          resp_flush_q <= 1'b1;
        end
      end
    end
  end

  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;
  assign cmd_flush_o  = cmd_flush_q;
  assign resp_flush_o = resp_flush_q;

  always_comb begin
    rdata  = '0;
    rd_err = 1'b0;
    case (paddr_i)
      hci_pkg::RESET_CONTROL_ADDR: begin
        rdata[hci_pkg::CMD_QUEUE_RST_BIT]  = cmd_rst_q;
        rdata[hci_pkg::RESP_QUEUE_RST_BIT] = resp_rst_q;
      end
      hci_pkg::QUEUE_THLD_CTRL_ADDR: begin
        rdata[hci_pkg::CMD_THLD_LSB +: hci_pkg::THLD_W]  = cmd_thld_q;
        rdata[hci_pkg::RESP_THLD_LSB +: hci_pkg::THLD_W] = resp_thld_q;
      end
      hci_pkg::COMMAND_PORT_ADDR: ;  // Write only port reads zero
      hci_pkg::RESPONSE_PORT_ADDR: begin
        if (resp_empty) begin
          rd_err = !pwrite_i;  // Underflow
        end else begin
          rdata = resp_rdata_i;
        end
      end
      hci_pkg::QUEUE_STATUS_ADDR: begin
        rdata[hci_pkg::CMD_CNT_LSB +: hci_pkg::CNT_W]  = cmd_count_i;
        rdata[hci_pkg::RESP_CNT_LSB +: hci_pkg::CNT_W] = resp_count_i;
        rdata[hci_pkg::CMD_FULL_BIT]                   = cmd_full;
        rdata[hci_pkg::RESP_EMPTY_BIT]                 = resp_empty;
      end
      default: rd_err = 1'b1;
    endcase
  end

  assign prdata_o  = rdata;
  assign pslverr_o = access && pready_o && rd_err;

  // Pop strobe lasts one access cycle
  a_pop_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) resp_pop_o |=> !resp_pop_o
  );

endmodule

// File: source/hci_pkg.sv
// Shared constants of the HCI PIO path
// Register map, data widths, queue sizing and field positions
package hci_pkg;

  localparam int unsigned APB_AW  = 12;
  localparam int unsigned DWORD_W = 32;
  localparam int unsigned CMD_W   = 64;
  localparam int unsigned THLD_W  = 8;

  localparam int unsigned QUEUE_DEPTH = 16;
  localparam int unsigned PTR_W       = $clog2(QUEUE_DEPTH);
  localparam int unsigned CNT_W       = 5;  // Holds 0 to QUEUE_DEPTH

  // Depth and threshold limits at the widths they are compared in
  localparam logic [CNT_W-1:0]  DEPTH_CNT  = CNT_W'(QUEUE_DEPTH);
  localparam logic [THLD_W-1:0] DEPTH_THLD = THLD_W'(QUEUE_DEPTH);
  localparam logic [THLD_W-1:0] THLD_MIN   = THLD_W'(1);

  // Register offsets
  localparam logic [APB_AW-1:0] RESET_CONTROL_ADDR   = APB_AW'('h10);
  localparam logic [APB_AW-1:0] QUEUE_THLD_CTRL_ADDR = APB_AW'('h20);
  localparam logic [APB_AW-1:0] COMMAND_PORT_ADDR    = APB_AW'('h30);
  localparam logic [APB_AW-1:0] RESPONSE_PORT_ADDR   = APB_AW'('h34);
  localparam logic [APB_AW-1:0] QUEUE_STATUS_ADDR    = APB_AW'('h38);

  // RESET_CONTROL
  localparam int unsigned CMD_QUEUE_RST_BIT  = 1;
  localparam int unsigned RESP_QUEUE_RST_BIT = 2;

  // QUEUE_THLD_CTRL
  localparam int unsigned CMD_THLD_LSB  = 0;
  localparam int unsigned RESP_THLD_LSB = 8;

  // QUEUE_STATUS
  localparam int unsigned CMD_CNT_LSB    = 0;
  localparam int unsigned RESP_CNT_LSB   = 8;
  localparam int unsigned CMD_FULL_BIT   = 16;
  localparam int unsigned RESP_EMPTY_BIT = 17;

endpackage

// File: source/hci_queue.sv
// Synchronous FIFO for HCI descriptors
// Fill count, registered threshold trigger and soft flush
`timescale 1ns/1ps

module hci_queue #(
  parameter int unsigned DataWidth  = 32,
  parameter bit          TrigOnFree = 1'b0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [DataWidth-1:0]       wdata_i,

  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [DataWidth-1:0]       rdata_o,

  input  logic [hci_pkg::THLD_W-1:0] thld_i,
  input  logic                       flush_i,
  output logic [hci_pkg::CNT_W-1:0]  count_o,
  output logic                       thld_trig_o,
  output logic                       flush_done_o
);

  logic [DataWidth-1:0]        mem_q [hci_pkg::QUEUE_DEPTH];
  logic [hci_pkg::PTR_W-1:0]   wr_ptr_q;
  logic [hci_pkg::PTR_W-1:0]   rd_ptr_q;
  logic [hci_pkg::CNT_W-1:0]   count_q;
  logic                        push;
  logic                        pop;
  logic [hci_pkg::CNT_W-1:0]   level;
  logic [hci_pkg::THLD_W-1:0]  level_ext;
  logic                        trig_q;
  logic                        flush_done_q;

  assign wready_o = (count_q != hci_pkg::DEPTH_CNT) && !flush_i;
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rd_ptr_q];
  assign count_o  = count_q;

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Depth is a power of two
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wdata_i;
  end

  // Free entries for a write queue, stored ones for a read queue
  always_comb begin
    if (TrigOnFree) begin
      level = hci_pkg::DEPTH_CNT - count_q;
    end else begin
      level = count_q;
    end
    level_ext                       = '0;
    level_ext[hci_pkg::CNT_W-1:0]   = level;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trig_q       <= 1'b0;
      flush_done_q <= 1'b0;
    end else begin
      trig_q       <= (level_ext >= thld_i);
      flush_done_q <= flush_i;
    end
  end

  assign thld_trig_o  = trig_q;
  assign flush_done_o = flush_done_q;

  a_count_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni) count_q <= hci_pkg::DEPTH_CNT
  );

  // Head entry holds until the consumer takes it
  a_rdata_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (rvalid_o && !rready_i && !flush_i) |=> $stable(rdata_o)
  );

endmodule

// File: source/hci_top.sv
// HCI PIO path top level
// APB registers feed the command packer and queues, responses return to APB
`timescale 1ns/1ps

module hci_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [hci_pkg::APB_AW-1:0]  paddr_i,
  input  logic [hci_pkg::DWORD_W-1:0] pwdata_i,
  output logic [hci_pkg::DWORD_W-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,

  output logic                        hci_cmd_rvalid_o,
  input  logic                        hci_cmd_rready_i,
  output logic [hci_pkg::CMD_W-1:0]   hci_cmd_rdata_o,

  input  logic                        hci_resp_wvalid_i,
  output logic                        hci_resp_wready_o,
  input  logic [hci_pkg::DWORD_W-1:0] hci_resp_wdata_i,

  output logic                        hci_cmd_ready_thld_trig_o,
  output logic                        hci_resp_ready_thld_trig_o
);

  logic                        cmd_dword_valid;
  logic [hci_pkg::DWORD_W-1:0] cmd_dword;
  logic                        cmd_dword_ready;
  logic                        packed_valid;
  logic                        packed_ready;
  logic [hci_pkg::CMD_W-1:0]   packed_data;

  logic [hci_pkg::THLD_W-1:0]  cmd_thld;
  logic                        cmd_flush;
  logic                        cmd_flush_done;
  logic [hci_pkg::CNT_W-1:0]   cmd_count;

  logic [hci_pkg::THLD_W-1:0]  resp_thld;
  logic                        resp_flush;
  logic                        resp_flush_done;
  logic [hci_pkg::CNT_W-1:0]   resp_count;
  logic                        resp_pop;
  logic [hci_pkg::DWORD_W-1:0] resp_rdata;

  hci_csr u_csr (
    .clk_i, .rst_ni,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .cmd_dword_ready_i (cmd_dword_ready),
    .cmd_count_i       (cmd_count),
    .cmd_flush_done_i  (cmd_flush_done),
    .resp_count_i      (resp_count),
    .resp_rdata_i      (resp_rdata),
    .resp_flush_done_i (resp_flush_done),
    .cmd_dword_valid_o (cmd_dword_valid),
    .cmd_dword_o       (cmd_dword),
    .cmd_thld_o        (cmd_thld),
    .cmd_flush_o       (cmd_flush),
    .resp_thld_o       (resp_thld),
    .resp_flush_o      (resp_flush),
    .resp_pop_o        (resp_pop)
  );

  cmd_dword_packer u_packer (
    .clk_i, .rst_ni,
    .dword_valid_i (cmd_dword_valid),
    .dword_i       (cmd_dword),
    .flush_i       (cmd_flush),  // Soft reset also drops a half command
    .cmd_wready_i  (packed_ready),
    .dword_ready_o (cmd_dword_ready),
    .cmd_wvalid_o  (packed_valid),
    .cmd_wdata_o   (packed_data)
  );

  hci_queue #(.DataWidth(hci_pkg::CMD_W), .TrigOnFree(1'b1)) u_cmd_queue (
    .clk_i, .rst_ni,
    .wvalid_i (packed_valid),   .wready_o (packed_ready),     .wdata_i (packed_data),
    .rvalid_o (hci_cmd_rvalid_o), .rready_i (hci_cmd_rready_i), .rdata_o (hci_cmd_rdata_o),
    .thld_i   (cmd_thld),       .flush_i  (cmd_flush),        .count_o (cmd_count),
    .thld_trig_o  (hci_cmd_ready_thld_trig_o),
    .flush_done_o (cmd_flush_done)
  );

  hci_queue #(.DataWidth(hci_pkg::DWORD_W), .TrigOnFree(1'b0)) u_resp_queue (
    .clk_i, .rst_ni,
    .wvalid_i (hci_resp_wvalid_i), .wready_o (hci_resp_wready_o), .wdata_i (hci_resp_wdata_i),
    .rvalid_o (),                  .rready_i (resp_pop),          .rdata_o (resp_rdata),
    .thld_i   (resp_thld),         .flush_i  (resp_flush),        .count_o (resp_count),
    .thld_trig_o  (hci_resp_ready_thld_trig_o),
    .flush_done_o (resp_flush_done)
  );

endmodule

// File: tb.f
source/hci_pkg.sv
source/hci_queue.sv
source/cmd_dword_packer.sv
source/hci_csr.sv
source/hci_top.sv
sim/tb_hci.sv
